//--- rv_core.f
+incdir+include
verilog/core_pkg.sv
verilog/fetch_pc.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/rv_core.sv
dv/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) verilog/rv_core.sv --top-module rv_core

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/rv_core_tb.sv
// --------------------------------------------------
// Testbench for rv_core
// Program is assembled into a sparse word memory
// Stores land at 0x200 upwards, one slot per check
// Fetch stalls come from an LFSR, about 3 cycles in 4 ready
// --------------------------------------------------

`default_nettype none

`include "core_defs.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] POISON = 32'hDEAD_BEEF;
  localparam logic [31:0] SEED   = 32'h2945_c7fd;

  logic        clk_i = 1'b0;
  logic        rst_i = 1'b0;
  logic        inst_ready_i = 1'b0;
  logic [31:0] inst_data_i = '0;
  logic [31:0] inst_addr_o;
  logic        data_qvalid_o;
  logic [31:0] data_qaddr_o;
  logic [31:0] data_qdata_o;

  logic [31:0] imem [int unsigned];
  bit          trap_at [int unsigned];
  logic [31:0] exp_data [0:63];
  string       exp_name [0:63];
  int          n_exp = 0;
  int          store_cnt = 0;
  int          errors = 0;
  int          prog_len = 0;
  logic [31:0] pc_asm;
  logic [31:0] slot = 32'h200;
  logic        prog_gen = 1'b0;
  logic        trap_fetch = 1'b0;
  logic [31:0] lfsr = SEED;
  logic        bit_a, bit_b;
  bit          timed_out = 0;

  rv_core DUT (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .inst_addr_o   (inst_addr_o),
    .inst_data_i   (inst_data_i),
    .inst_ready_i  (inst_ready_i),
    .data_qvalid_o (data_qvalid_o),
    .data_qaddr_o  (data_qaddr_o),
    .data_qdata_o  (data_qdata_o)
  );

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  // Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  always @(posedge clk_i) begin
    lfsr = lfsr_next(lfsr);
    bit_a = lfsr[0];
    lfsr = lfsr_next(lfsr);
    bit_b = lfsr[0];
    inst_ready_i <= bit_a | bit_b;
  end

  // Unmapped fetches return zero, an illegal word
  always @(inst_addr_o or inst_ready_i or prog_gen) begin
    inst_data_i = imem.exists(inst_addr_o) ? imem[inst_addr_o] : 32'h0;
    trap_fetch  = inst_ready_i && trap_at.exists(inst_addr_o);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i && data_qvalid_o) begin
      store_cnt <= store_cnt + 1;
    end
  end

  // --------------------------------------------------
  // Instruction encoders
  // --------------------------------------------------
  function automatic logic [31:0] op_r(input logic [6:0] f7, input int rs2, input int rs1,
                                       input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] op_i(input logic [11:0] imm, input int rs1,
                                       input logic [2:0] f3, input int rd, input logic [6:0] op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic logic [31:0] op_sw(input int rs2, input int rs1, input logic [11:0] imm);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] op_b(input logic [12:0] imm, input int rs2, input int rs1,
                                       input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] op_u(input logic [19:0] imm, input int rd, input logic [6:0] op);
    return {imm, 5'(rd), op};
  endfunction

  function automatic logic [31:0] op_jal(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
  endfunction

  task automatic put(input logic [31:0] w);
    imem[pc_asm] = w;
    pc_asm = pc_asm + 4;
    prog_len++;
  endtask

  task automatic expect_next(input logic [31:0] value, input string name);
    exp_data[n_exp] = value;
    exp_name[n_exp] = name;
    n_exp++;
    slot = slot + 4;
  endtask

  task automatic store_reg(input int rs, input logic [31:0] value, input string name);
    put(op_sw(rs, 0, slot[11:0]));
    expect_next(value, name);
  endtask

  // Sets the handler's store slot and resume address, then the faulting word
  task automatic trap_case(input logic [31:0] word, input logic [31:0] marker,
                           input string name);
    put(op_i(slot[11:0], 0, 3'b000, 22, 7'b0010011));
    expect_next(marker, name);
    put(op_u(20'h0, 24, 7'b0010111));
    put(op_i(12'd12, 24, 3'b000, 24, 7'b0010011));
    trap_at[pc_asm] = 1'b1;
    put(word);
  endtask

  task automatic build_program();
    logic [31:0] here;
    pc_asm = `CORE_BOOT_ADDR;
    put(op_i(12'd5, 0, 3'b000, 1, 7'b0010011));
    store_reg(1, 32'h5, "addi");
    put(op_i(12'hffd, 0, 3'b000, 2, 7'b0010011));
    put(op_i(12'h7a0, 0, 3'b000, 20, 7'b0010011));
    put(op_u(20'hDEADC, 15, 7'b0110111));
    put(op_i(12'heef, 15, 3'b000, 15, 7'b0010011));
    put(op_r(7'h00, 2, 1, 3'b000, 3));
    store_reg(3, 32'h2, "add");
    put(op_r(7'h20, 2, 1, 3'b000, 4));
    store_reg(4, 32'h8, "sub");
    put(op_r(7'h00, 2, 1, 3'b100, 5));
    store_reg(5, 32'hffff_fff8, "xor");
    put(op_r(7'h00, 2, 1, 3'b110, 6));
    store_reg(6, 32'hffff_fffd, "or");
    put(op_r(7'h00, 2, 1, 3'b111, 7));
    store_reg(7, 32'h5, "and");
    put(op_r(7'h00, 1, 2, 3'b010, 8));
    store_reg(8, 32'h1, "slt");
    put(op_r(7'h00, 1, 2, 3'b011, 9));
    store_reg(9, 32'h0, "sltu");
    put(op_i(12'h004, 1, 3'b001, 10, 7'b0010011));
    store_reg(10, 32'h50, "slli");
    put(op_i(12'h01c, 2, 3'b101, 11, 7'b0010011));
    store_reg(11, 32'hf, "srli");
    put(op_i(12'h401, 2, 3'b101, 12, 7'b0010011));
    store_reg(12, 32'hffff_fffe, "srai");
    put(op_u(20'h12345, 13, 7'b0110111));
    store_reg(13, 32'h1234_5000, "lui");
    here = pc_asm;
    put(op_u(20'h00001, 14, 7'b0010111));
    store_reg(14, here + 32'h1000, "auipc");
    put(op_i(12'd7, 0, 3'b000, 0, 7'b0010011));
    store_reg(0, 32'h0, "x0");

    // Taken branches skip a poison store
    put(op_b(13'd8, 1, 1, 3'b000));
    put(op_sw(15, 0, 12'h300));
    put(op_b(13'd8, 2, 1, 3'b001));
    put(op_sw(15, 0, 12'h300));
    put(op_b(13'd8, 1, 2, 3'b100));
    put(op_sw(15, 0, 12'h300));
    put(op_b(13'd8, 1, 2, 3'b111));
    put(op_sw(15, 0, 12'h300));
    put(op_b(13'd8, 2, 1, 3'b000));
    store_reg(1, 32'h5, "beq not taken");

    here = pc_asm;
    put(op_jal(21'd8, 16));
    put(op_sw(15, 0, 12'h300));
    store_reg(16, here + 4, "jal link");
    here = pc_asm;
    put(op_u(20'h0, 17, 7'b0010111));
    put(op_i(12'd16, 17, 3'b000, 18, 7'b1100111));
    put(op_sw(15, 0, 12'h300));
    put(op_sw(15, 0, 12'h300));
    store_reg(18, here + 8, "jalr link");

    trap_case(op_sw(1, 0, 12'h202), 32'h7a1, "misaligned sw");
    trap_case(32'h0, 32'h7a2, "illegal word");
    put(op_jal(21'd0, 0));

    // Trap handler bumps the marker and returns through x24
    pc_asm = `CORE_TRAP_ADDR;
    put(op_i(12'd1, 20, 3'b000, 20, 7'b0010011));
    put(op_sw(20, 22, 12'h0));
    put(op_i(12'd0, 24, 3'b000, 0, 7'b1100111));
  endtask

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_reset: assert property (@(posedge clk_i) (rst_i || $past(rst_i))
    |-> (inst_addr_o == `CORE_BOOT_ADDR && !data_qvalid_o))
    else begin
      errors++;
      $display("ERR reset expected fetch %h strobe 0 actual fetch %h strobe %b",
               `CORE_BOOT_ADDR, $sampled(inst_addr_o), $sampled(data_qvalid_o));
    end

  a_store_data: assert property (@(posedge clk_i) disable iff (rst_i)
    data_qvalid_o |-> (store_cnt < n_exp && data_qdata_o == exp_data[store_cnt]))
    else begin
      errors++;
      $display("ERR %s expected %h actual %h", exp_name[$sampled(store_cnt)],
               exp_data[$sampled(store_cnt)], $sampled(data_qdata_o));
    end

  a_store_addr: assert property (@(posedge clk_i) disable iff (rst_i)
    data_qvalid_o |-> data_qaddr_o == 32'h200 + 32'(store_cnt) * 4)
    else begin
      errors++;
      $display("ERR %s address expected %h actual %h", exp_name[$sampled(store_cnt)],
               32'h200 + 32'($sampled(store_cnt)) * 4, $sampled(data_qaddr_o));
    end

  a_no_poison: assert property (@(posedge clk_i) disable iff (rst_i)
    data_qvalid_o |-> data_qdata_o != POISON)
    else begin
      errors++;
      $display("Poison value stored, a branch or jump did not skip");
    end

  a_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    !inst_ready_i |-> !data_qvalid_o ##1 $stable(inst_addr_o))
    else begin
      errors++;
      $display("Stalled cycle issued a store or moved the fetch address");
    end

  a_trap: assert property (@(posedge clk_i) disable iff (rst_i)
    trap_fetch |-> !data_qvalid_o ##1 (inst_addr_o == `CORE_TRAP_ADDR))
    else begin
      errors++;
      $display("Faulting instruction stored or did not jump to the trap vector");
    end

  // --------------------------------------------------
  // Run control
  // --------------------------------------------------
  initial begin
    rst_i <= 1'b1;
    build_program();
    prog_gen = 1'b1;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    fork
      begin
        wait (store_cnt == n_exp);
        repeat (20) @(posedge clk_i);
      end
      begin
        #((4 * prog_len + 8) * 8);
        timed_out = 1;
      end
    join_any
    disable fork;
    if (timed_out) begin
      errors++;
      $display("Watchdog expired with %0d of %0d stores seen", store_cnt, n_exp);
    end
    $display("stores %0d of %0d, errors %0d", store_cnt, n_exp, errors);
    if (errors == 0 && store_cnt == n_exp) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
// --------------------------------------------------
// Single-issue RV32I core without loads or CSRs
// One instruction retires per cycle with inst_ready_i high
// inst_data_i must be valid in the same cycle as the address
// data_qvalid_o is a one-cycle strobe with no back-pressure
// --------------------------------------------------

`default_nettype none

module rv_core (
  input  logic            clk_i,
  input  logic            rst_i,
  output core_pkg::addr_t inst_addr_o,
  input  core_pkg::inst_t inst_data_i,
  input  logic            inst_ready_i,
  output logic            data_qvalid_o,
  output core_pkg::addr_t data_qaddr_o,
  output core_pkg::word_t data_qdata_o
);
  import core_pkg::*;

  alu_op_e  alu_op;
  opa_sel_e opa_sel;
  opb_sel_e opb_sel;
  next_pc_e next_sel;
  word_t    imm;
  reg_idx_t rs1, rs2, rd;
  logic     rf_we;
  logic     is_branch;
  logic     store;
  logic [1:0] wb_sel;
  word_t    rdata_a, rdata_b;
  word_t    opa, opb;
  word_t    alu_result;
  word_t    wb_data;
  addr_t    pc;
  addr_t    link;

  fetch_pc i_fetch_pc (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .en_i        (inst_ready_i),
    .next_sel_i  (next_sel),
    .is_branch_i (is_branch),
    .cond_i      (alu_result[0]),
    .target_i    (alu_result),
    .offset_i    (imm),
    .pc_o        (pc),
    .link_o      (link)
  );

  // Write enable and store strobe are qualified by inst_ready_i here
  decoder i_decoder (
    .inst_i       (inst_data_i),
    .valid_i      (inst_ready_i),
    .alu_result_i (alu_result),
    .alu_op_o     (alu_op),
    .opa_sel_o    (opa_sel),
    .opb_sel_o    (opb_sel),
    .imm_o        (imm),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rd_o         (rd),
    .rd_we_o      (rf_we),
    .wb_sel_o     (wb_sel),
    .is_branch_o  (is_branch),
    .next_sel_o   (next_sel),
    .store_o      (store)
  );

  regfile i_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .waddr_i   (rd),
    .we_i      (rf_we),
    .wdata_i   (wb_data),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  // --------------------------------------------------
  // Operand select
  // --------------------------------------------------
  always_comb begin
    unique case (opa_sel)
      RegA:    opa = rdata_a;
      Pc:      opa = pc;
      default: opa = '0;
    endcase
  end

  always_comb begin
    unique case (opb_sel)
      RegB:    opb = rdata_b;
      default: opb = imm;
    endcase
  end

  alu i_alu (
    .op_i     (alu_op),
    .opa_i    (opa),
    .opb_i    (opb),
    .result_o (alu_result)
  );

  // Write-back selects the link address for jumps and the U-immediate for LUI
  always_comb begin
    unique case (wb_sel)
      2'd1:    wb_data = link;
      2'd2:    wb_data = imm;
      default: wb_data = alu_result;
    endcase
  end

  assign inst_addr_o   = pc;
  assign data_qvalid_o = store;
  assign data_qaddr_o  = alu_result;
  assign data_qdata_o  = rdata_b;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_store_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    data_qvalid_o |-> (!rf_we && next_sel != Trap));

endmodule

`default_nettype wire

//--- verilog/alu.sv
// --------------------------------------------------
// Purely combinational shared ALU
// One 33-bit adder covers add, subtract and compares
// Compare results are returned in bit 0
// --------------------------------------------------

`default_nettype none

module alu (
  input  core_pkg::alu_op_e op_i,
  input  core_pkg::word_t   opa_i,
  input  core_pkg::word_t   opb_i,
  output core_pkg::word_t   result_o
);
  import core_pkg::*;

  logic        subtract;
  logic        signed_cmp;
  logic [32:0] add_a;
  logic [32:0] add_b;
  logic [32:0] add_sum;
  logic        less;
  logic        equal;

  // --------------------------------------------------
  // Adder
  // --------------------------------------------------
  assign subtract   = (op_i != Add);
  assign signed_cmp = (op_i == Slt) || (op_i == Ge);

  // Extra top bit keeps the sign of the difference without overflow
  assign add_a   = {signed_cmp & opa_i[31], opa_i};
  assign add_b   = {signed_cmp & opb_i[31], opb_i};
  assign add_sum = add_a + (subtract ? ~add_b : add_b) + {32'b0, subtract};
  assign less    = add_sum[32];
  assign equal   = (add_sum[31:0] == 32'b0);

  // --------------------------------------------------
  // Shifter
  // --------------------------------------------------
  logic        shift_left;
  logic        shift_arith;
  word_t       opa_reversed;
  word_t       shift_in;
  word_t       shift_right;
  word_t       shift_left_res;
  logic [32:0] shift_ext;
  logic [32:0] shift_right_ext;

  assign shift_left  = (op_i == Sll);
  assign shift_arith = (op_i == Sra);

  // Left shift is a right shift of the bit-reversed operand
  for (genvar i = 0; i < 32; i++) begin : gen_reverse
    assign opa_reversed[i]   = opa_i[31-i];
    assign shift_left_res[i] = shift_right[31-i];
  end

  assign shift_in        = shift_left ? opa_reversed : opa_i;
  assign shift_ext       = {shift_arith & shift_in[31], shift_in};
  assign shift_right_ext = $unsigned($signed(shift_ext) >>> opb_i[4:0]);
  assign shift_right     = shift_right_ext[31:0];

  // Result select
  always_comb begin
    result_o = '0;
    unique case (op_i)
      Add, Sub: result_o = add_sum[31:0];
      Sll:      result_o = shift_left_res;
      Srl, Sra: result_o = shift_right;
      Xor:      result_o = opa_i ^ opb_i;
      Or:       result_o = opa_i | opb_i;
      And:      result_o = opa_i & opb_i;
      Eq:       result_o[0] = equal;
      Neq:      result_o[0] = !equal;
      Slt, Sltu: result_o[0] = less;
      Ge, Geu:  result_o[0] = !less;
      default:  result_o = add_sum[31:0];
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/regfile.sv
// --------------------------------------------------
// Integer register file with two read ports and one write port
// Reads are combinational, writes land at the clock edge
// x0 has no storage and always reads as zero
// --------------------------------------------------

`default_nettype none

`include "core_defs.svh"

module regfile (
  input  logic               clk_i,
  input  logic               rst_i,
  input  core_pkg::reg_idx_t raddr_a_i,
  input  core_pkg::reg_idx_t raddr_b_i,
  input  core_pkg::reg_idx_t waddr_i,
  input  logic               we_i,
  input  core_pkg::word_t    wdata_i,
  output core_pkg::word_t    rdata_a_o,
  output core_pkg::word_t    rdata_b_o
);
  import core_pkg::*;

  // Registers x1 and up
  word_t regs_q [1:`CORE_NUM_REGS-1];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 1; i < `CORE_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- verilog/decoder.sv
// --------------------------------------------------
// RV32I decoder for the kept instruction subset
// Only SW is a legal store, SB and SH trap
// Store address is checked on the ALU result
// wb_sel_o selects 0 ALU result, 1 PC plus 4, 2 immediate
// --------------------------------------------------

`default_nettype none

module decoder (
  input  core_pkg::inst_t    inst_i,
  input  logic               valid_i,
  input  core_pkg::word_t    alu_result_i,
  output core_pkg::alu_op_e  alu_op_o,
  output core_pkg::opa_sel_e opa_sel_o,
  output core_pkg::opb_sel_e opb_sel_o,
  output core_pkg::word_t    imm_o,
  output core_pkg::reg_idx_t rs1_o,
  output core_pkg::reg_idx_t rs2_o,
  output core_pkg::reg_idx_t rd_o,
  output logic               rd_we_o,
  output logic [1:0]         wb_sel_o,
  output logic               is_branch_o,
  output core_pkg::next_pc_e next_sel_o,
  output logic               store_o
);
  import core_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      i_imm, s_imm, b_imm, u_imm, j_imm;
  alu_op_e    arith_op;
  logic       bad_funct7;
  logic       illegal;
  logic       write_rd;
  logic       is_store;
  logic       misaligned;
  logic       exception;
  next_pc_e   next_pc;

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rd_o   = inst_i[11:7];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];

  // Immediate formats
  assign i_imm = {{20{inst_i[31]}}, inst_i[31:20]};
  assign s_imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign u_imm = {inst_i[31:12], 12'b0};
  assign j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // Only ADD/SUB and SRL/SRA have an alternate funct7
  assign bad_funct7 = !(funct7 == 7'b0000000 ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));

  always_comb begin
    unique case (funct3)
      3'b000:  arith_op = (opcode == OP && funct7[5]) ? Sub : Add;
      3'b001:  arith_op = Sll;
      3'b010:  arith_op = Slt;
      3'b011:  arith_op = Sltu;
      3'b100:  arith_op = Xor;
      3'b101:  arith_op = funct7[5] ? Sra : Srl;
      3'b110:  arith_op = Or;
      default: arith_op = And;
    endcase
  end

  // --------------------------------------------------
  // Main decode
  // --------------------------------------------------
  always_comb begin
    alu_op_o    = Add;
    opa_sel_o   = RegA;
    opb_sel_o   = Imm;
    imm_o       = i_imm;
    wb_sel_o    = 2'd0;
    write_rd    = 1'b1;
    is_branch_o = 1'b0;
    is_store    = 1'b0;
    next_pc     = Consec;
    illegal     = 1'b0;

    unique case (opcode)
      OP: begin
        alu_op_o  = arith_op;
        opb_sel_o = RegB;
        illegal   = bad_funct7;
      end
      OP_IMM: begin
        alu_op_o = arith_op;
        // Shift amount sits in the immediate, funct7 still constrained
        illegal  = (funct3 == 3'b001 || funct3 == 3'b101) && bad_funct7;
      end
      LUI: begin
        opa_sel_o = Zero;
        imm_o     = u_imm;
        wb_sel_o  = 2'd2;
      end
      AUIPC: begin
        opa_sel_o = Pc;
        imm_o     = u_imm;
      end
      JAL: begin
        opa_sel_o = Pc;
        imm_o     = j_imm;
        wb_sel_o  = 2'd1;
        next_pc   = Target;
      end
      JALR: begin
        wb_sel_o = 2'd1;
        next_pc  = Target;
        illegal  = (funct3 != 3'b000);
      end
      BRANCH: begin
        opb_sel_o   = RegB;
        imm_o       = b_imm;
        write_rd    = 1'b0;
        is_branch_o = 1'b1;
        unique case (funct3)
          3'b000:  alu_op_o = Eq;
          3'b001:  alu_op_o = Neq;
          3'b100:  alu_op_o = Slt;
          3'b101:  alu_op_o = Ge;
          3'b110:  alu_op_o = Sltu;
          3'b111:  alu_op_o = Geu;
          default: illegal = 1'b1;
        endcase
      end
      STORE: begin
        imm_o    = s_imm;
        write_rd = 1'b0;
        is_store = 1'b1;
        illegal  = (funct3 != 3'b010);
      end
      default: illegal = 1'b1;
    endcase
  end

  // --------------------------------------------------
  // Trap and side effects
  // --------------------------------------------------
  assign misaligned = is_store && (alu_result_i[1:0] != 2'b00);
  assign exception  = illegal || misaligned;

  assign rd_we_o    = valid_i && write_rd && !exception;
  assign store_o    = valid_i && is_store && !exception;
  assign next_sel_o = exception ? Trap : next_pc;

endmodule

`default_nettype wire

//--- verilog/fetch_pc.sv
// --------------------------------------------------
// Program counter and next-PC selection
// The PC only advances in cycles with en_i high
// Jump targets must be word aligned, only bit 0 is cleared
// --------------------------------------------------

`default_nettype none

`include "core_defs.svh"

module fetch_pc (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              en_i,
  input  core_pkg::next_pc_e next_sel_i,
  input  logic              is_branch_i,
  input  logic              cond_i,
  input  core_pkg::addr_t   target_i,
  input  core_pkg::word_t   offset_i,
  output core_pkg::addr_t   pc_o,
  output core_pkg::addr_t   link_o
);
  import core_pkg::*;

  addr_t pc_q;
  addr_t pc_d;
  addr_t consec_pc;

  // Taken branches add the B offset, everything else steps one word
  assign consec_pc = pc_q + ((is_branch_i && cond_i) ? offset_i : addr_t'(4));
  assign link_o    = pc_q + addr_t'(4);

  always_comb begin
    unique case (next_sel_i)
      Target:  pc_d = target_i & ~addr_t'(1);
      Trap:    pc_d = `CORE_TRAP_ADDR;
      default: pc_d = consec_pc;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc_q <= `CORE_BOOT_ADDR;
    end else if (en_i) begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

  a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i) pc_q[1:0] == 2'b00)
    else $error("PC not word aligned: %h", pc_q);

endmodule

`default_nettype wire

//--- verilog/core_pkg.sv
// --------------------------------------------------
// Shared types of the integer core
// Widths follow the macros in core_defs.svh
// Opcode values are the RV32I major opcodes
// --------------------------------------------------

`default_nettype none

`include "core_defs.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]              word_t;
  typedef logic [`CORE_XLEN-1:0]              addr_t;
  typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;
  typedef logic [31:0]                        inst_t;

  // Major opcodes that the core executes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    Add, Sub,
    Sll, Srl, Sra,
    Xor, Or, And,
    Eq, Neq, Slt, Sltu, Ge, Geu
  } alu_op_e;

  typedef enum logic [1:0] {RegA, Pc, Zero} opa_sel_e;

  typedef enum logic [1:0] {RegB, Imm} opb_sel_e;

  typedef enum logic [1:0] {Consec, Target, Trap} next_pc_e;

endpackage

`default_nettype wire

//--- include/core_defs.svh
// --------------------------------------------------
// Core wide constants for the RV32I integer core
// Data and address width are fixed at 32 bits and the
// decoder slices assume this width
// The register count must match the 5-bit index fields
// Boot and trap addresses must be word aligned
// --------------------------------------------------

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data path and address width
`define CORE_XLEN 32

// Architectural integer registers, x0 included
`define CORE_NUM_REGS 32

// PC after reset
`define CORE_BOOT_ADDR 32'h0000_1000

// Fixed vector for illegal instructions and misaligned stores
`define CORE_TRAP_ADDR 32'h0000_0100

`endif
